// ==== tb/cpu_vectors.mem ====
// Word 0 is the number of tests
// Per test: 16 program words, output count, expected outputs, final flags as {N,C,Z}
04
// Test 1: LDA and LDB, then ADD, AND, OR, SUB each followed by OUTA
1E 2F 40 90 60 90 70 90 50 90 F0 00 00 00 C8 64
04 2C 24 64 00
01
// Test 2: LDI, SUB with borrow, STA then OUTM, LDA of the stored word, ADD carry
35 2F 50 8E 30 AE 90 1E 40 90 50 90 F0 00 00 09
04 FC 00 05 FC
06
// Test 3: countdown loop on JZ and JMP, JC and JN not taken then taken
33 2F 90 50 C6 B2 DA EA 50 DB 90 ED F0 90 F0 01
04 03 02 01 FF
06
// Test 4: JN on loaded data, ADD loop left on carry, JZ after LDI 0, OUTM
1F E3 F0 2E 40 90 D8 B4 30 CB 90 AF F0 00 20 C0
03 E0 00 C0
01

// ==== src.f ====
logic/arch_defs_pkg.sv
logic/control_pkg.sv
logic/program_counter.sv
logic/alu.sv
logic/flag_unit.sv
logic/control_unit.sv
logic/cpu.sv
logic/program_ram.sv
logic/cpu_system.sv
tb/cpu_system_sva.sv
tb/tb_cpu_system.sv

// ==== Bender.yml ====
package:
  name: cpu_system

sources:
  - logic/arch_defs_pkg.sv
  - logic/control_pkg.sv
  - logic/program_counter.sv
  - logic/alu.sv
  - logic/flag_unit.sv
  - logic/control_unit.sv
  - logic/cpu.sv
  - logic/program_ram.sv
  - logic/cpu_system.sv
  - target: test
    files:
      - tb/cpu_system_sva.sv
      - tb/tb_cpu_system.sv

// ==== tb/tb_cpu_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_system;

    import arch_defs_pkg::*;

    // ============================================================
    // Run limits and vector layout
    // ============================================================
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int MAX_RUN_CYCLES = 2000;
    // Cycles kept running after halt to catch late outputs
    localparam int TAIL_CYCLES    = 6;
    localparam int VEC_DEPTH      = 128;

    logic                  clk;
    logic                  arst_n;
    logic                  run;
    logic                  load_we;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [DATA_WIDTH-1:0] load_data;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  halt;
    logic                  flag_zero;
    logic                  flag_carry;
    logic                  flag_negative;

    // Programs and expected results, walked by vec_idx
    logic [DATA_WIDTH-1:0] vectors [VEC_DEPTH];
    logic [DATA_WIDTH-1:0] outputs_q [$];
    logic [31:0]           lfsr_q;
    int                    vec_idx;

    cpu_system #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .run_i           (run),
        .load_we_i       (load_we),
        .load_addr_i     (load_addr),
        .load_data_i     (load_data),
        .out_valid_o     (out_valid),
        .out_data_o      (out_data),
        .halt_o          (halt),
        .flag_zero_o     (flag_zero),
        .flag_carry_o    (flag_carry),
        .flag_negative_o (flag_negative)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Flag pins packed in Z, C, N bit order
    function automatic logic [FLAG_COUNT-1:0] flags_now();
        logic [FLAG_COUNT-1:0] f;
        f[FLAG_Z] = flag_zero;
        f[FLAG_C] = flag_carry;
        f[FLAG_N] = flag_negative;
        return f;
    endfunction

    task automatic abort_run(input string reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_data(input string what, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_flags(input string what, input logic [FLAG_COUNT-1:0] got,
                               input logic [FLAG_COUNT-1:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s NCZ=%b, expected %b", $time, what, got, exp);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run("status bit mismatch");
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run("output count mismatch");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n  = 1'b0;
        run     = 1'b0;
        load_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // Program written through the load port, CPU idle
    task automatic load_program(input int base);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = ADDR_WIDTH'(i);
            load_data = vectors[base + i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    // ============================================================
    // Run with random pauses until halt
    // ============================================================
    task automatic run_until_halt();
        int                    cycles;
        logic                  halt_seen;
        logic                  pause_a;
        logic                  pause_b;
        logic [FLAG_COUNT-1:0] flags_prev;
        logic [DATA_WIDTH-1:0] out_prev;
        cycles    = 0;
        halt_seen = 1'b0;
        outputs_q.delete();
        while (!halt_seen) begin
            if (cycles >= MAX_RUN_CYCLES) begin
                abort_run("timeout, halt_o never rose while running the program");
            end else begin
                // Pause on one cycle in four
                lfsr_q  = lfsr_next(lfsr_q);
                pause_a = lfsr_q[0];
                lfsr_q  = lfsr_next(lfsr_q);
                pause_b = lfsr_q[0];
                run        = !(pause_a && pause_b);
                flags_prev = flags_now();
                out_prev   = out_data;
                @(negedge clk);
                cycles++;
                // A paused edge must leave visible state alone
                if (!run) begin
                    check_flags("flags across pause", flags_now(), flags_prev);
                    check_data("out_data_o across pause", out_data, out_prev);
                    check_bit("out_valid_o after pause", out_valid, 1'b0);
                end
                if (out_valid) begin
                    outputs_q.push_back(out_data);
                end
                halt_seen = halt;
            end
        end
        // Halted CPU stays quiet
        run = 1'b1;
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_bit("out_valid_o after halt", out_valid, 1'b0);
            check_bit("halt_o after halt", halt, 1'b1);
        end
        run = 1'b0;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int                    test_count;
        int                    out_count;
        logic [FLAG_COUNT-1:0] exp_flags;
        clk       = 1'b0;
        arst_n    = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr_q    = 32'h19639479;
        $readmemh("tb/cpu_vectors.mem", vectors);
        test_count = int'(vectors[0]);
        check_bit("vector file holds tests", (test_count > 0), 1'b1);
        vec_idx = 1;
        for (int t = 0; t < test_count; t++) begin
            apply_reset();
            // Idle state, run still low
            check_bit("halt_o after reset", halt, 1'b0);
            check_bit("out_valid_o after reset", out_valid, 1'b0);
            check_flags("flags after reset", flags_now(), '0);
            load_program(vec_idx);
            vec_idx += MEM_DEPTH;
            run_until_halt();
            out_count = int'(vectors[vec_idx]);
            vec_idx++;
            check_count($sformatf("output count of test %0d", t), outputs_q.size(), out_count);
            for (int k = 0; k < out_count; k++) begin
                check_data($sformatf("output %0d of test %0d", k, t), outputs_q[k],
                           vectors[vec_idx]);
                vec_idx++;
            end
            exp_flags = vectors[vec_idx][FLAG_COUNT-1:0];
            vec_idx++;
            check_flags($sformatf("flags at halt of test %0d", t), flags_now(), exp_flags);
        end
        // Bound strobe and halt assertions
        if (dut_i.u_cpu.u_cpu_system_sva.error_count != 0) begin
            abort_run("a bound assertion on the memory strobes or halt_o failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/cpu_system_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_system_sva (
    input logic clk,
    input logic arst_n_i,
    input logic run_i,
    input logic mem_read_i,
    input logic mem_write_i,
    input logic halt_i
);

    // Failed assertion count
    int unsigned error_count = 0;

    // RAM port carries one direction per cycle
    read_write_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mem_read_i && mem_write_i))
        else begin
            error_count++;
            $error("mem_read_o and mem_write_o high in the same cycle");
        end

    // Idle CPU leaves the memory alone
    no_strobe_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        !run_i |-> (!mem_read_i && !mem_write_i))
        else begin
            error_count++;
            $error("memory strobe while run_i is low");
        end

    // Sticky halt
    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
        halt_i |=> halt_i)
        else begin
            error_count++;
            $error("halt_o fell without reset");
        end

endmodule

bind cpu cpu_system_sva u_cpu_system_sva (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .run_i       (run_i),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .halt_i      (halt_o)
);

`default_nettype wire

// ==== logic/cpu_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_system #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  run_i,
    // RAM load port, used while idle
    input  logic                  load_we_i,
    input  logic [ADDR_WIDTH-1:0] load_addr_i,
    input  logic [DATA_WIDTH-1:0] load_data_i,
    output logic                  out_valid_o,
    output logic [DATA_WIDTH-1:0] out_data_o,
    output logic                  halt_o,
    output logic                  flag_zero_o,
    output logic                  flag_carry_o,
    output logic                  flag_negative_o
);

    // CPU to RAM wires
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic [DATA_WIDTH-1:0] mem_wdata;

    cpu #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_cpu (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .run_i           (run_i),
        .mem_addr_o      (mem_addr),
        .mem_read_o      (mem_read),
        .mem_write_o     (mem_write),
        .mem_rdata_i     (mem_rdata),
        .mem_wdata_o     (mem_wdata),
        .out_valid_o     (out_valid_o),
        .out_data_o      (out_data_o),
        .halt_o          (halt_o),
        .flag_zero_o     (flag_zero_o),
        .flag_carry_o    (flag_carry_o),
        .flag_negative_o (flag_negative_o)
    );

    program_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_program_ram (
        .clk         (clk),
        .mem_addr_i  (mem_addr),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

`default_nettype wire

// ==== logic/program_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_ram #(
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  logic                                 clk,
    // CPU port
    input  logic [ADDR_WIDTH-1:0]                mem_addr_i,
    input  logic                                 mem_read_i,
    input  logic                                 mem_write_i,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] mem_wdata_i,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] mem_rdata_o,
    // Testbench load port
    input  logic                                 load_we_i,
    input  logic [ADDR_WIDTH-1:0]                load_addr_i,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] load_data_i
);

    import arch_defs_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Load port has priority over CPU writes
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (mem_write_i) begin
            mem[mem_addr_i] <= mem_wdata_i;
        end
    end

    // Same-cycle read while strobed
    assign mem_rdata_o = mem_read_i ? mem[mem_addr_i] : '0;

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  run_i,
    // Memory port, read data is combinational
    output logic [ADDR_WIDTH-1:0] mem_addr_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    input  logic [DATA_WIDTH-1:0] mem_rdata_i,
    output logic [DATA_WIDTH-1:0] mem_wdata_o,
    // Output register
    output logic                  out_valid_o,
    output logic [DATA_WIDTH-1:0] out_data_o,
    output logic                  halt_o,
    output logic                  flag_zero_o,
    output logic                  flag_carry_o,
    output logic                  flag_negative_o
);

    import arch_defs_pkg::*;
    import control_pkg::*;

    control_word_t            cw;
    logic [DATA_WIDTH-1:0]    internal_bus;
    logic [DATA_WIDTH-1:0]    a_q;
    logic [DATA_WIDTH-1:0]    b_q;
    logic [DATA_WIDTH-1:0]    ir_q;
    logic [DATA_WIDTH-1:0]    out_q;
    logic [DATA_WIDTH-1:0]    alu_result;
    logic [ADDR_WIDTH-1:0]    mar_q;
    logic [ADDR_WIDTH-1:0]    pc;
    logic                     out_valid_q;
    opcode_t                  opcode;
    logic [OPERAND_WIDTH-1:0] operand;
    logic [FLAG_COUNT-1:0]    flags;
    logic                     alu_zero;
    logic                     alu_carry;
    logic                     alu_negative;

    // Instruction fields
    assign opcode  = opcode_t'(ir_q[DATA_WIDTH-1 -: OPCODE_WIDTH]);
    assign operand = ir_q[OPERAND_WIDTH-1:0];

    // ============================================================
    // Internal bus
    // ============================================================

    // Priority order RAM, ALU, A, immediate
    always_comb begin
        if (cw.oe_ram) begin
            internal_bus = mem_rdata_i;
        end else if (cw.oe_alu) begin
            internal_bus = alu_result;
        end else if (cw.oe_a) begin
            internal_bus = a_q;
        end else if (cw.oe_imm) begin
            internal_bus = DATA_WIDTH'(operand);
        end else begin
            internal_bus = '0;
        end
    end

    // ============================================================
    // Datapath registers
    // ============================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_q   <= '0;
            b_q   <= '0;
            ir_q  <= '0;
            mar_q <= '0;
        end else if (run_i) begin
            if (cw.load_a) begin
                a_q <= internal_bus;
            end
            if (cw.load_b) begin
                b_q <= internal_bus;
            end
            if (cw.load_ir) begin
                ir_q <= internal_bus;
            end
            // Fetch address or data address
            if (cw.load_mar) begin
                mar_q <= cw.mar_src_operand ? ADDR_WIDTH'(operand) : pc;
            end
        end
    end

    // Valid pulse lines up with the new output data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= run_i & cw.load_o;
        end
    end

    always_ff @(posedge clk) begin
        if (run_i && cw.load_o) begin
            out_q <= internal_bus;
        end
    end

    // Strobes only while running
    assign mem_addr_o      = mar_q;
    assign mem_read_o      = run_i & cw.oe_ram;
    assign mem_write_o     = run_i & cw.load_ram;
    assign mem_wdata_o     = a_q;
    assign out_valid_o     = out_valid_q;
    assign out_data_o      = out_q;
    assign halt_o          = cw.halt;
    assign flag_zero_o     = flags[FLAG_Z];
    assign flag_carry_o    = flags[FLAG_C];
    assign flag_negative_o = flags[FLAG_N];

    // ============================================================
    // Submodules
    // ============================================================
    program_counter #(.ADDR_WIDTH(ADDR_WIDTH)) u_program_counter (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .run_i    (run_i),
        .inc_i    (cw.pc_enable),
        .load_i   (cw.load_pc),
        .addr_i   (ADDR_WIDTH'(operand)),
        .pc_o     (pc)
    );

    alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .run_i      (run_i),
        .a_i        (a_q),
        .b_i        (b_q),
        .op_i       (cw.alu_op),
        .result_o   (alu_result),
        .zero_o     (alu_zero),
        .carry_o    (alu_carry),
        .negative_o (alu_negative)
    );

    flag_unit #(.DATA_WIDTH(DATA_WIDTH)) u_flag_unit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .run_i          (run_i),
        .load_flags_i   (cw.load_flags),
        .load_sets_zn_i (cw.load_sets_zn),
        .opcode_i       (opcode),
        .operand_i      (operand),
        .bus_i          (internal_bus),
        .alu_zero_i     (alu_zero),
        .alu_carry_i    (alu_carry),
        .alu_negative_i (alu_negative),
        .flags_o        (flags)
    );

    control_unit u_control_unit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .run_i          (run_i),
        .opcode_i       (opcode),
        .flags_i        (flags),
        .control_word_o (cw)
    );

endmodule

`default_nettype wire

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic                                 run_i,
    input  arch_defs_pkg::opcode_t               opcode_i,
    input  logic [arch_defs_pkg::FLAG_COUNT-1:0] flags_i,
    output control_pkg::control_word_t           control_word_o
);

    import arch_defs_pkg::*;
    import control_pkg::*;

    // Four microsteps T0..T3
    localparam int STEP_WIDTH = 2;

    logic [STEP_WIDTH-1:0] step_q;
    logic                  halted_q;
    logic                  jump_taken;
    control_word_t         rom_word;

    // ============================================================
    // Microcode ROM
    // ============================================================
    always_comb begin
        rom_word = '0;
        unique case (step_q)
            // Fetch address from PC
            2'd0: rom_word.load_mar = 1'b1;
            // Fetch instruction, advance PC
            2'd1: begin
                rom_word.oe_ram    = 1'b1;
                rom_word.load_ir   = 1'b1;
                rom_word.pc_enable = 1'b1;
            end
            2'd2: begin
                unique case (opcode_i)
                    NOP: rom_word.step_reset = 1'b1;
                    LDI: begin
                        rom_word.oe_imm       = 1'b1;
                        rom_word.load_a       = 1'b1;
                        rom_word.load_flags   = 1'b1;
                        rom_word.load_sets_zn = 1'b1;
                        rom_word.step_reset   = 1'b1;
                    end
                    OUTA: begin
                        rom_word.oe_a       = 1'b1;
                        rom_word.load_o     = 1'b1;
                        rom_word.step_reset = 1'b1;
                    end
                    // Jump target comes from the operand
                    JMP, JZ, JC, JN: begin
                        rom_word.load_pc    = 1'b1;
                        rom_word.step_reset = 1'b1;
                    end
                    HLT: begin
                        rom_word.halt       = 1'b1;
                        rom_word.step_reset = 1'b1;
                    end
                    // Memory access, point MAR at the operand
                    LDA, LDB, STA, OUTM: begin
                        rom_word.load_mar        = 1'b1;
                        rom_word.mar_src_operand = 1'b1;
                    end
                    // ALU latches its result this step
                    ADD: rom_word.alu_op = ALU_ADD;
                    SUB: rom_word.alu_op = ALU_SUB;
                    AND: rom_word.alu_op = ALU_AND;
                    OR:  rom_word.alu_op = ALU_OR;
                endcase
            end
            2'd3: begin
                rom_word.step_reset = 1'b1;
                unique case (opcode_i)
                    LDA, LDB: begin
                        rom_word.oe_ram       = 1'b1;
                        rom_word.load_a       = (opcode_i == LDA);
                        rom_word.load_b       = (opcode_i == LDB);
                        rom_word.load_flags   = 1'b1;
                        rom_word.load_sets_zn = 1'b1;
                    end
                    STA: begin
                        rom_word.oe_a     = 1'b1;
                        rom_word.load_ram = 1'b1;
                    end
                    OUTM: begin
                        rom_word.oe_ram = 1'b1;
                        rom_word.load_o = 1'b1;
                    end
                    // Latched ALU result into A with its flags
                    ADD, SUB, AND, OR: begin
                        rom_word.oe_alu     = 1'b1;
                        rom_word.load_a     = 1'b1;
                        rom_word.load_flags = 1'b1;
                    end
                    default: ;
                endcase
            end
        endcase
    end

    // Conditional jump decision
    always_comb begin
        unique case (opcode_i)
            JZ:      jump_taken = flags_i[FLAG_Z];
            JC:      jump_taken = flags_i[FLAG_C];
            JN:      jump_taken = flags_i[FLAG_N];
            default: jump_taken = 1'b1;
        endcase
    end

    // Once halted only the halt bit stays on
    always_comb begin
        control_word_o         = rom_word;
        control_word_o.load_pc = rom_word.load_pc & jump_taken;
        if (halted_q) begin
            control_word_o      = '0;
            control_word_o.halt = 1'b1;
        end
    end

    // ============================================================
    // Microstep counter and sticky halt
    // ============================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            step_q   <= '0;
            halted_q <= 1'b0;
        end else if (run_i && !halted_q) begin
            if (rom_word.halt) begin
                halted_q <= 1'b1;
            end
            if (rom_word.step_reset) begin
                step_q <= '0;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/flag_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_unit #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    arst_n_i,
    input  logic                                    run_i,
    input  logic                                    load_flags_i,
    input  logic                                    load_sets_zn_i,
    input  arch_defs_pkg::opcode_t                  opcode_i,
    input  logic [arch_defs_pkg::OPERAND_WIDTH-1:0] operand_i,
    input  logic [DATA_WIDTH-1:0]                   bus_i,
    input  logic                                    alu_zero_i,
    input  logic                                    alu_carry_i,
    input  logic                                    alu_negative_i,
    output logic [arch_defs_pkg::FLAG_COUNT-1:0]    flags_o
);

    import arch_defs_pkg::*;

    logic [DATA_WIDTH-1:0] load_data;
    logic                  load_zero;
    logic                  load_negative;
    logic [FLAG_COUNT-1:0] flags_d;
    logic [FLAG_COUNT-1:0] flags_q;

    // ============================================================
    // Load data checker
    // ============================================================

    // LDI sees the zero-extended immediate, LDA and LDB the bus
    assign load_data     = (opcode_i == LDI) ? DATA_WIDTH'(operand_i) : bus_i;
    assign load_zero     = (load_data == '0);
    assign load_negative = load_data[DATA_WIDTH-1];

    // Select between load checker and ALU flags
    always_comb begin
        flags_d[FLAG_Z] = alu_zero_i;
        flags_d[FLAG_C] = alu_carry_i;
        flags_d[FLAG_N] = alu_negative_i;
        if (load_sets_zn_i) begin
            flags_d[FLAG_Z] = load_zero;
            // Loads always clear carry
            flags_d[FLAG_C] = 1'b0;
            flags_d[FLAG_N] = load_negative;
        end
    end

    // Flag register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flags_q <= '0;
        end else if (run_i && load_flags_i) begin
            flags_q <= flags_d;
        end
    end

    assign flags_o = flags_q;

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   run_i,
    input  logic [DATA_WIDTH-1:0]  a_i,
    input  logic [DATA_WIDTH-1:0]  b_i,
    input  control_pkg::alu_op_t   op_i,
    output logic [DATA_WIDTH-1:0]  result_o,
    output logic                   zero_o,
    output logic                   carry_o,
    output logic                   negative_o
);

    import control_pkg::*;

    // One extra bit holds carry out or borrow
    logic [DATA_WIDTH:0] wide_result;

    always_comb begin
        wide_result = '0;
        unique case (op_i)
            ALU_ADD: wide_result = {1'b0, a_i} + {1'b0, b_i};
            // Top bit set when b exceeds a
            ALU_SUB: wide_result = {1'b0, a_i} - {1'b0, b_i};
            // Logic operations never carry
            ALU_AND: wide_result = {1'b0, a_i & b_i};
            ALU_OR:  wide_result = {1'b0, a_i | b_i};
        endcase
    end

    // Result and flags latched together
    // Sampled by the datapath one step later
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o   <= '0;
            zero_o     <= 1'b0;
            carry_o    <= 1'b0;
            negative_o <= 1'b0;
        end else if (run_i) begin
            result_o   <= wide_result[DATA_WIDTH-1:0];
            zero_o     <= (wide_result[DATA_WIDTH-1:0] == '0);
            carry_o    <= wide_result[DATA_WIDTH];
            negative_o <= wide_result[DATA_WIDTH-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  run_i,
    input  logic                  inc_i,
    input  logic                  load_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    output logic [ADDR_WIDTH-1:0] pc_o
);

    logic [ADDR_WIDTH-1:0] pc_q;

    // Jump load wins over increment
    // Counter wraps at the top of the address space
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else if (run_i) begin
            if (load_i) begin
                pc_q <= addr_i;
            end else if (inc_i) begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== logic/control_pkg.sv ====
`default_nettype none

package control_pkg;

    // ALU function select
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_t;

    // ============================================================
    // Microcode control word
    // ============================================================
    typedef struct packed {
        // Register loads from the internal bus
        logic    load_a;
        logic    load_b;
        logic    load_ir;
        logic    load_pc;
        logic    load_mar;
        logic    load_ram;
        logic    load_o;
        logic    load_flags;
        // Flags come from loaded data instead of the ALU
        logic    load_sets_zn;
        // Bus drivers, RAM has highest priority
        logic    oe_ram;
        logic    oe_a;
        logic    oe_alu;
        logic    oe_imm;
        // Sequencing
        logic    mar_src_operand;
        logic    pc_enable;
        logic    halt;
        logic    step_reset;
        alu_op_t alu_op;
    } control_word_t;

endpackage

`default_nettype wire

// ==== logic/arch_defs_pkg.sv ====
`default_nettype none

package arch_defs_pkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    // Data word and instruction word share one width
    localparam int DATA_WIDTH = 8;
    // RAM address and program counter width
    localparam int ADDR_WIDTH = 4;
    // Instruction split into opcode nibble and operand nibble
    localparam int OPCODE_WIDTH = 4;
    localparam int OPERAND_WIDTH = 4;
    // Words in program RAM
    localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

    // ============================================================
    // Status flags
    // ============================================================

    localparam int FLAG_COUNT = 3;
    // Bit positions inside the flag vector
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;

    // Instruction set, upper nibble of the instruction word
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        LDA  = 4'd1,
        LDB  = 4'd2,
        LDI  = 4'd3,
        ADD  = 4'd4,
        SUB  = 4'd5,
        AND  = 4'd6,
        OR   = 4'd7,
        STA  = 4'd8,
        OUTA = 4'd9,
        OUTM = 4'd10,
        JMP  = 4'd11,
        JZ   = 4'd12,
        JC   = 4'd13,
        JN   = 4'd14,
        HLT  = 4'd15
    } opcode_t;

endpackage

`default_nettype wire
